//--- tc_cfg_pkg.sv
// trace cache configuration with line geometry, derived widths and decay timing
package tc_cfg_pkg;

	// cache geometry
	localparam int NUM_LINES = 8;	// trace lines, fully associative
	localparam int NRETIRE = 4;	// bundles per line and per retired group

	// halfword pc, held as bits [PC_BITS:1]
	localparam int PC_BITS = 15;

	// derived index widths
	localparam int LINE_IDX_BITS = $clog2(NUM_LINES);
	localparam int SLOT_IDX_BITS = $clog2(NRETIRE);

	// use counters, one per line
	localparam int USE_BITS = 3;
	localparam logic [USE_BITS-1:0] USE_MAX = 3'd7;	// saturation value
	localparam logic [USE_BITS-1:0] USE_ON_WRITE = 3'd2;	// given to a fresh line

	// decay timer
	// scale 0 uses the base period, otherwise (scale+1) steps
	localparam int DECAY_BASE = 64;
	localparam int DECAY_STEP = 16;
	localparam int DECAY_CNT_BITS = 9;	// holds 16*16-1

	// fetch advance on a miss, in halfwords
	localparam logic [PC_BITS:1] MISS_PC_STEP = 15'd8;

endpackage

//--- tc_types_pkg.sv
// trace cache types for retired bundles, trace groups and the lookup result
package tc_types_pkg;

	// execution unit class of a retired instruction
	typedef enum logic [1:0] {
		alu,
		load,
		store,
		branch
	} unit_e;

	// one retired instruction
	typedef struct packed {
		logic [tc_cfg_pkg::PC_BITS:1] pc;
		logic [31:0] insn;
		unit_e unit;
		logic short_ins;	// compressed, one halfword
		logic taken;	// only meaningful for branch
		logic [tc_cfg_pkg::PC_BITS:1] target;
	} bundle_t;

	// a retired group coming in, or a line's contents going out
	typedef struct packed {
		logic [tc_cfg_pkg::NRETIRE-1:0] valid;
		bundle_t [tc_cfg_pkg::NRETIRE-1:0] b;
	} trace_group_t;

	// registered lookup result
	typedef struct packed {
		logic hit;
		logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] idx;
		trace_group_t group;
	} lookup_t;

endpackage

//--- tc_tag_array.sv
// trace cache tag array holding valid masks, tags and next pcs with the associative compares
`timescale 1ns/1ps

module tc_tag_array (
	input  logic clk,
	input  logic rst_n,
	input  logic trace_enable,
	input  logic [3:0] cpu_mode,
	input  logic invalidate,
	input  logic [tc_cfg_pkg::PC_BITS:1] pc,
	input  logic [tc_cfg_pkg::PC_BITS:1] fill_pc,
	input  logic write,
	input  logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] write_idx,
	input  logic [tc_cfg_pkg::PC_BITS:1] write_tag,
	input  logic [tc_cfg_pkg::PC_BITS:1] write_next,
	input  logic [tc_cfg_pkg::NRETIRE-1:0] write_mask,
	output logic [tc_cfg_pkg::NUM_LINES-1:0] match,
	output logic [tc_cfg_pkg::NUM_LINES-1:0] line_valid,
	output logic fill_present,
	output logic [tc_cfg_pkg::PC_BITS:1] pc_next,
	output logic clear
);

	logic [tc_cfg_pkg::NRETIRE-1:0] r_valid [tc_cfg_pkg::NUM_LINES];
	logic [tc_cfg_pkg::PC_BITS:1] r_tag [tc_cfg_pkg::NUM_LINES];
	logic [tc_cfg_pkg::PC_BITS:1] r_next [tc_cfg_pkg::NUM_LINES];
	logic [3:0] r_cpu_mode;
	logic r_clear;	// invalidate, one cycle late
	logic [tc_cfg_pkg::NUM_LINES-1:0] fill_match;
	logic [tc_cfg_pkg::PC_BITS:1] hit_next;

	always_ff @(posedge clk) begin
		r_cpu_mode <= cpu_mode;
	end

	// a mode switch flushes everything, same as an explicit invalidate
	always_ff @(posedge clk) begin
		if (!rst_n)
			r_clear <= 1'b0;
		else
			r_clear <= invalidate || cpu_mode != r_cpu_mode;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < tc_cfg_pkg::NUM_LINES; i++) begin
			if (!rst_n || r_clear || !trace_enable)
				r_valid[i] <= '0;	// cache off keeps every line empty
			else if (write && write_idx == i[tc_cfg_pkg::LINE_IDX_BITS-1:0])
				r_valid[i] <= write_mask;
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			r_tag[write_idx] <= write_tag;
			r_next[write_idx] <= write_next;
		end
	end

	// lookup and fill compares, slot 0 valid marks a live line
	always_comb begin
		hit_next = '0;
		for (int i = 0; i < tc_cfg_pkg::NUM_LINES; i++) begin
			line_valid[i] = r_valid[i][0];
			match[i] = line_valid[i] && r_tag[i] == pc;
			fill_match[i] = line_valid[i] && r_tag[i] == fill_pc;
			hit_next = hit_next | ({tc_cfg_pkg::PC_BITS{match[i]}} & r_next[i]);	// one-hot mux
		end
	end

	assign fill_present = |fill_match;
	assign pc_next = |match ? hit_next : pc + tc_cfg_pkg::MISS_PC_STEP;
	assign clear = r_clear;

endmodule

//--- tc_data_array.sv
// trace cache data array with bundle storage, one-hot read and the registered lookup result
`timescale 1ns/1ps

module tc_data_array (
	input  logic clk,
	input  logic rst_n,
	input  logic rename_stall,
	input  logic [tc_cfg_pkg::NUM_LINES-1:0] match,
	input  logic write,
	input  logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] write_idx,
	input  tc_types_pkg::trace_group_t write_group,
	output tc_types_pkg::lookup_t result
);

	tc_types_pkg::trace_group_t r_line [tc_cfg_pkg::NUM_LINES];
	logic [$bits(tc_types_pkg::trace_group_t)-1:0] sel_bits;
	logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] sel_idx;
	logic r_hit;
	logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] r_idx;
	tc_types_pkg::trace_group_t r_group;

	// per-slot strobes, only the valid run is stored
	always_ff @(posedge clk) begin
		if (write) begin
			r_line[write_idx].valid <= write_group.valid;
			for (int s = 0; s < tc_cfg_pkg::NRETIRE; s++) begin
				if (write_group.valid[s])
					r_line[write_idx].b[s] <= write_group.b[s];
			end
		end
	end

	// and-or read mux and index encode, match is one-hot
	always_comb begin
		sel_bits = '0;
		sel_idx = '0;
		for (int i = 0; i < tc_cfg_pkg::NUM_LINES; i++) begin
			sel_bits = sel_bits | ({$bits(tc_types_pkg::trace_group_t){match[i]}} & r_line[i]);
			if (match[i])
				sel_idx = sel_idx | i[tc_cfg_pkg::LINE_IDX_BITS-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			r_hit <= 1'b0;
		else if (!rename_stall)
			r_hit <= |match;
	end

	always_ff @(posedge clk) begin
		if (!rename_stall) begin	// rename not ready, hold the last result
			r_idx <= sel_idx;
			r_group <= tc_types_pkg::trace_group_t'(sel_bits);
		end
	end

	assign result = '{hit: r_hit, idx: r_idx, group: r_group};

endmodule

//--- tc_line_alloc.sv
// trace cache line allocator with use counters, decay timer and victim selection
`timescale 1ns/1ps

module tc_line_alloc (
	input  logic clk,
	input  logic rst_n,
	input  logic [3:0] trace_scale,
	input  logic pc_used,
	input  logic result_hit,
	input  logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] result_idx,
	input  logic [tc_cfg_pkg::NUM_LINES-1:0] line_valid,
	input  logic [tc_cfg_pkg::NUM_LINES-1:0] match,
	input  logic clear,
	input  logic write,
	input  logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] write_idx,
	output logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] victim_idx,
	output logic victim_ok
);

	logic [tc_cfg_pkg::DECAY_CNT_BITS-1:0] r_decay;
	logic [tc_cfg_pkg::DECAY_CNT_BITS-1:0] reload;
	logic tick;
	logic [tc_cfg_pkg::USE_BITS-1:0] r_use [tc_cfg_pkg::NUM_LINES];
	logic [tc_cfg_pkg::NUM_LINES-1:0] pend;	// line taken by the write in flight
	logic [tc_cfg_pkg::NUM_LINES-1:0] free;
	logic [tc_cfg_pkg::NUM_LINES-1:0] idle;

	// decay period minus one
	always_comb begin
		if (trace_scale == 4'd0)
			reload = tc_cfg_pkg::DECAY_CNT_BITS'(tc_cfg_pkg::DECAY_BASE - 1);
		else
			reload = tc_cfg_pkg::DECAY_CNT_BITS'((trace_scale + 5'd1) * tc_cfg_pkg::DECAY_STEP - 1);
	end

	assign tick = r_decay == '0;

	always_ff @(posedge clk) begin
		if (!rst_n || tick)
			r_decay <= reload;
		else
			r_decay <= r_decay - 1'b1;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < tc_cfg_pkg::NUM_LINES; i++) begin
			if (!rst_n || clear) begin
				r_use[i] <= '0;
			end else if (write && write_idx == i[tc_cfg_pkg::LINE_IDX_BITS-1:0]) begin
				r_use[i] <= tc_cfg_pkg::USE_ON_WRITE;
			end else if (result_hit && pc_used &&
					result_idx == i[tc_cfg_pkg::LINE_IDX_BITS-1:0]) begin
				if (r_use[i] != tc_cfg_pkg::USE_MAX)
					r_use[i] <= r_use[i] + 1'b1;	// consumed hit
			end else if (tick && r_use[i] != '0) begin
				r_use[i] <= r_use[i] - 1'b1;
			end
		end
	end

	// lowest index wins, so scan from the top down
	always_comb begin
		victim_ok = 1'b0;
		victim_idx = '0;
		for (int i = 0; i < tc_cfg_pkg::NUM_LINES; i++) begin
			pend[i] = write && write_idx == i[tc_cfg_pkg::LINE_IDX_BITS-1:0];
			free[i] = !line_valid[i] && !pend[i];
			idle[i] = r_use[i] == '0 && !match[i] && !pend[i];	// never evict the line being read
		end
		if (|free) begin
			victim_ok = 1'b1;
			for (int i = tc_cfg_pkg::NUM_LINES - 1; i >= 0; i--) begin
				if (free[i])
					victim_idx = i[tc_cfg_pkg::LINE_IDX_BITS-1:0];
			end
		end else if (|idle) begin
			victim_ok = 1'b1;
			for (int i = tc_cfg_pkg::NUM_LINES - 1; i >= 0; i--) begin
				if (idle[i])
					victim_idx = i[tc_cfg_pkg::LINE_IDX_BITS-1:0];
			end
		end
	end

endmodule

//--- tc_fill_ctrl.sv
// trace cache fill control that turns a retired group into a registered line write
`timescale 1ns/1ps

module tc_fill_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic trace_enable,
	input  tc_types_pkg::trace_group_t trace_in,
	input  logic fill_present,
	input  logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] victim_idx,
	input  logic victim_ok,
	output logic [tc_cfg_pkg::PC_BITS:1] fill_pc,
	output logic write,
	output logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] write_idx,
	output logic [tc_cfg_pkg::PC_BITS:1] write_tag,
	output logic [tc_cfg_pkg::PC_BITS:1] write_next,
	output logic [tc_cfg_pkg::NRETIRE-1:0] write_mask,
	output tc_types_pkg::trace_group_t write_group
);

	logic [tc_cfg_pkg::NRETIRE-1:0] run;	// leading run of valid slots
	logic [tc_cfg_pkg::SLOT_IDX_BITS-1:0] last;
	tc_types_pkg::bundle_t last_b;
	logic branched;
	logic [tc_cfg_pkg::PC_BITS:1] next_pc;
	logic present;
	logic do_write;
	logic r_write;
	logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] r_idx;
	logic [tc_cfg_pkg::PC_BITS:1] r_tag;
	logic [tc_cfg_pkg::PC_BITS:1] r_next;
	tc_types_pkg::trace_group_t r_group;

	always_comb begin
		run[0] = trace_in.valid[0];
		last = '0;
		for (int s = 1; s < tc_cfg_pkg::NRETIRE; s++) begin
			run[s] = run[s-1] && trace_in.valid[s];
			if (run[s])
				last = s[tc_cfg_pkg::SLOT_IDX_BITS-1:0];
		end
	end

	// next pc comes from the last slot written
	assign last_b = trace_in.b[last];
	assign branched = last_b.unit == tc_types_pkg::branch && last_b.taken;
	assign next_pc = branched ? last_b.target :
		last_b.pc + {{(tc_cfg_pkg::PC_BITS-2){1'b0}}, ~last_b.short_ins, last_b.short_ins};

	assign fill_pc = trace_in.b[0].pc;

	// the write still in flight is not yet visible in the tags
	assign present = fill_present || (r_write && r_tag == fill_pc);
	assign do_write = trace_enable && trace_in.valid[0] && !present && victim_ok;

	always_ff @(posedge clk) begin
		if (!rst_n)
			r_write <= 1'b0;
		else
			r_write <= do_write;
	end

	always_ff @(posedge clk) begin
		if (do_write) begin
			r_idx <= victim_idx;
			r_tag <= fill_pc;
			r_next <= next_pc;
			r_group.valid <= run;
			r_group.b <= trace_in.b;
		end
	end

	assign write = r_write;
	assign write_idx = r_idx;
	assign write_tag = r_tag;
	assign write_next = r_next;
	assign write_mask = r_group.valid;
	assign write_group = r_group;

endmodule

//--- trace_cache_top.sv
// trace cache top level joining tag and data arrays, line allocator and fill control
`timescale 1ns/1ps

module trace_cache_top (
	input  logic clk,
	input  logic rst_n,
	input  logic trace_enable,
	input  logic [3:0] trace_scale,
	input  logic [3:0] cpu_mode,
	input  logic invalidate,
	input  logic [tc_cfg_pkg::PC_BITS:1] pc,
	input  logic pc_used,
	input  logic rename_stall,
	input  tc_types_pkg::trace_group_t trace_in,
	output tc_types_pkg::lookup_t result,
	output logic [tc_cfg_pkg::PC_BITS:1] pc_next
);

	logic [tc_cfg_pkg::NUM_LINES-1:0] match;
	logic [tc_cfg_pkg::NUM_LINES-1:0] line_valid;
	logic fill_present;
	logic clear;
	logic [tc_cfg_pkg::PC_BITS:1] fill_pc;
	logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] victim_idx;
	logic victim_ok;

	// write command, shared by both arrays and the allocator
	logic write;
	logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] write_idx;
	logic [tc_cfg_pkg::PC_BITS:1] write_tag;
	logic [tc_cfg_pkg::PC_BITS:1] write_next;
	logic [tc_cfg_pkg::NRETIRE-1:0] write_mask;
	tc_types_pkg::trace_group_t write_group;

	tc_tag_array u_tag (
		.clk(clk), .rst_n(rst_n), .trace_enable(trace_enable), .cpu_mode(cpu_mode),
		.invalidate(invalidate), .pc(pc), .fill_pc(fill_pc), .write(write),
		.write_idx(write_idx), .write_tag(write_tag), .write_next(write_next),
		.write_mask(write_mask), .match(match), .line_valid(line_valid),
		.fill_present(fill_present), .pc_next(pc_next), .clear(clear)
	);

	tc_data_array u_data (
		.clk(clk), .rst_n(rst_n), .rename_stall(rename_stall), .match(match),
		.write(write), .write_idx(write_idx), .write_group(write_group), .result(result)
	);

	tc_line_alloc u_alloc (
		.clk(clk), .rst_n(rst_n), .trace_scale(trace_scale), .pc_used(pc_used),
		.result_hit(result.hit), .result_idx(result.idx), .line_valid(line_valid),
		.match(match), .clear(clear), .write(write), .write_idx(write_idx),
		.victim_idx(victim_idx), .victim_ok(victim_ok)
	);

	tc_fill_ctrl u_fill (
		.clk(clk), .rst_n(rst_n), .trace_enable(trace_enable), .trace_in(trace_in),
		.fill_present(fill_present), .victim_idx(victim_idx), .victim_ok(victim_ok),
		.fill_pc(fill_pc), .write(write), .write_idx(write_idx), .write_tag(write_tag),
		.write_next(write_next), .write_mask(write_mask), .write_group(write_group)
	);

endmodule

//--- tb_trace_cache.sv
// trace cache testbench running a table of fills, lookups, invalidations and stalls
`timescale 1ns/1ps

module tb_trace_cache;

	localparam logic [tc_cfg_pkg::PC_BITS:1] PARK_PC = 15'h7ff0;	// never used as a tag
	localparam int RESET_CYCLES = 5;
	localparam int MARGIN_CYCLES = 100;

	typedef enum int {
		OP_FILL,
		OP_LOOKUP,
		OP_IDLE,
		OP_INVAL,
		OP_MODE,
		OP_DISABLE,
		OP_STALL
	} op_e;

	typedef struct {
		op_e op;
		logic [tc_cfg_pkg::PC_BITS:1] pc;
		int grp;	// index into groups
		logic hit;
		logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] idx;
		logic [tc_cfg_pkg::NRETIRE-1:0] mask;
		logic [tc_cfg_pkg::PC_BITS:1] nxt;	// expected pc_next
		int cycles;	// idle length
	} step_t;

	logic clk;
	logic rst_n;
	logic trace_enable;
	logic [3:0] trace_scale;
	logic [3:0] cpu_mode;
	logic invalidate;
	logic [tc_cfg_pkg::PC_BITS:1] pc;
	logic pc_used;
	logic rename_stall;
	tc_types_pkg::trace_group_t trace_in;
	tc_types_pkg::lookup_t result;
	logic [tc_cfg_pkg::PC_BITS:1] pc_next;

	step_t steps [$];
	tc_types_pkg::trace_group_t groups [11];
	logic [15:0] lfsr_state;
	bit table_ready;

	trace_cache_top uut (
		.clk(clk), .rst_n(rst_n), .trace_enable(trace_enable), .trace_scale(trace_scale),
		.cpu_mode(cpu_mode), .invalidate(invalidate), .pc(pc), .pc_used(pc_used),
		.rename_stall(rename_stall), .trace_in(trace_in), .result(result), .pc_next(pc_next)
	);

	always #5 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		w = '0;
		for (int k = 0; k < 32; k++)
			w = {w[30:0], lfsr_bit()};
		return w;
	endfunction

	// slot pcs follow each other by one or two halfwords
	function automatic tc_types_pkg::trace_group_t make_group(
		input logic [tc_cfg_pkg::PC_BITS:1] base,
		input logic [tc_cfg_pkg::NRETIRE-1:0] valid,
		input logic [tc_cfg_pkg::NRETIRE-1:0] short_mask,
		input int br_slot,
		input logic br_taken,
		input logic [tc_cfg_pkg::PC_BITS:1] br_target);
		tc_types_pkg::trace_group_t g;
		logic [tc_cfg_pkg::PC_BITS:1] p;
		g = '0;
		g.valid = valid;
		p = base;
		for (int s = 0; s < tc_cfg_pkg::NRETIRE; s++) begin
			g.b[s].pc = p;
			g.b[s].insn = rand_word();
			g.b[s].short_ins = short_mask[s];
			if (s == br_slot) begin
				g.b[s].unit = tc_types_pkg::branch;
				g.b[s].taken = br_taken;
				g.b[s].target = br_target;
			end else begin
				g.b[s].unit = tc_types_pkg::unit_e'(s % 3);	// alu, load, store
			end
			p = p + (short_mask[s] ? 15'd1 : 15'd2);
		end
		return g;
	endfunction

	task automatic build_groups();
		groups[0] = make_group(15'h100, 4'b1111, 4'b1000, -1, 1'b0, 15'h0);
		groups[1] = make_group(15'h200, 4'b0111, 4'b0000, -1, 1'b0, 15'h0);
		groups[2] = make_group(15'h300, 4'b1011, 4'b0001, -1, 1'b0, 15'h0);	// hole at slot 2
		groups[3] = make_group(15'h400, 4'b1111, 4'b0000, 3, 1'b1, 15'h1234);
		groups[4] = make_group(15'h500, 4'b0011, 4'b0010, 1, 1'b0, 15'h0abc);	// not taken
		groups[5] = make_group(15'h100, 4'b0001, 4'b0000, -1, 1'b0, 15'h0);	// same tag as 0
		groups[6] = make_group(15'h600, 4'b1111, 4'b1111, -1, 1'b0, 15'h0);
		groups[7] = make_group(15'h700, 4'b0001, 4'b0000, -1, 1'b0, 15'h0);
		groups[8] = make_group(15'h800, 4'b0011, 4'b0000, 1, 1'b1, 15'h050);
		groups[9] = make_group(15'h900, 4'b1111, 4'b0000, -1, 1'b0, 15'h0);
		groups[10] = make_group(15'ha00, 4'b1111, 4'b0000, -1, 1'b0, 15'h0);
	endtask

	task automatic add_step(input op_e op, input logic [tc_cfg_pkg::PC_BITS:1] spc,
		input int grp, input logic hit, input logic [tc_cfg_pkg::LINE_IDX_BITS-1:0] idx,
		input logic [tc_cfg_pkg::NRETIRE-1:0] mask, input logic [tc_cfg_pkg::PC_BITS:1] nxt,
		input int cycles);
		steps.push_back('{op, spc, grp, hit, idx, mask, nxt, cycles});
	endtask

	task automatic build_table();
		add_step(OP_LOOKUP, 15'h100, 0, 1'b0, 3'd0, 4'b0000, 15'h108, 0);	// empty cache
		add_step(OP_FILL, 15'h0, 0, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h100, 0, 1'b1, 3'd0, 4'b1111, 15'h107, 0);
		add_step(OP_FILL, 15'h0, 1, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h200, 1, 1'b1, 3'd1, 4'b0111, 15'h206, 0);
		add_step(OP_FILL, 15'h0, 2, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h300, 2, 1'b1, 3'd2, 4'b0011, 15'h303, 0);
		add_step(OP_FILL, 15'h0, 3, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h400, 3, 1'b1, 3'd3, 4'b1111, 15'h1234, 0);
		// refill of a present tag is dropped
		add_step(OP_FILL, 15'h0, 5, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h100, 0, 1'b1, 3'd0, 4'b1111, 15'h107, 0);
		add_step(OP_FILL, 15'h0, 4, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h500, 4, 1'b1, 3'd4, 4'b0011, 15'h503, 0);
		add_step(OP_FILL, 15'h0, 6, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h600, 6, 1'b1, 3'd5, 4'b1111, 15'h604, 0);
		add_step(OP_FILL, 15'h0, 7, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h700, 7, 1'b1, 3'd6, 4'b0001, 15'h702, 0);
		add_step(OP_FILL, 15'h0, 8, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h800, 8, 1'b1, 3'd7, 4'b0011, 15'h050, 0);
		// result held at line 7 while pc moves on
		add_step(OP_STALL, 15'h200, 8, 1'b1, 3'd7, 4'b0011, 15'h206, 0);
		add_step(OP_STALL, 15'h300, 8, 1'b1, 3'd7, 4'b0011, 15'h303, 0);
		add_step(OP_LOOKUP, 15'h300, 2, 1'b1, 3'd2, 4'b0011, 15'h303, 0);
		// counts decay to zero, line 0 is the victim
		add_step(OP_IDLE, 15'h0, 0, 1'b0, 3'd0, 4'b0000, 15'h0, 200);
		add_step(OP_FILL, 15'h0, 9, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h100, 0, 1'b0, 3'd0, 4'b0000, 15'h108, 0);
		add_step(OP_LOOKUP, 15'h900, 9, 1'b1, 3'd0, 4'b1111, 15'h908, 0);
		add_step(OP_LOOKUP, 15'h200, 1, 1'b1, 3'd1, 4'b0111, 15'h206, 0);
		add_step(OP_INVAL, 15'h0, 0, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h900, 0, 1'b0, 3'd0, 4'b0000, 15'h908, 0);
		add_step(OP_LOOKUP, 15'h200, 0, 1'b0, 3'd0, 4'b0000, 15'h208, 0);
		add_step(OP_FILL, 15'h0, 10, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'ha00, 10, 1'b1, 3'd0, 4'b1111, 15'ha08, 0);
		add_step(OP_MODE, 15'h0, 0, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'ha00, 0, 1'b0, 3'd0, 4'b0000, 15'ha08, 0);
		add_step(OP_FILL, 15'h0, 1, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h200, 1, 1'b1, 3'd0, 4'b0111, 15'h206, 0);
		add_step(OP_DISABLE, 15'h0, 0, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h200, 0, 1'b0, 3'd0, 4'b0000, 15'h208, 0);
		add_step(OP_FILL, 15'h0, 3, 1'b0, 3'd0, 4'b0000, 15'h0, 0);
		add_step(OP_LOOKUP, 15'h400, 3, 1'b1, 3'd0, 4'b1111, 15'h1234, 0);
	endtask

	task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_result(input step_t s);
		check_value("result.hit", result.hit, s.hit);
		if (s.hit) begin
			check_value("result.idx", result.idx, s.idx);
			check_value("result valid mask", result.group.valid, s.mask);
			for (int b = 0; b < tc_cfg_pkg::NRETIRE; b++) begin
				if (s.mask[b])
					check_value($sformatf("result bundle %0d", b), result.group.b[b],
						groups[s.grp].b[b]);
			end
		end
	endtask

	function automatic int step_cycles(input step_t s);
		if (s.op == OP_IDLE)
			return s.cycles;
		else
			return 2;
	endfunction

	// called on a falling edge, returns on a falling edge
	task automatic apply_step(input step_t s);
		case (s.op)
			OP_FILL: begin
				pc = PARK_PC;	// keeps match low so any idle line can be the victim
				trace_in = groups[s.grp];
				@(negedge clk);
				trace_in = '0;
				@(negedge clk);	// registered write lands here
			end
			OP_LOOKUP, OP_STALL: begin
				pc = s.pc;
				rename_stall = s.op == OP_STALL;
				#1;
				check_value("pc_next", pc_next, s.nxt);
				@(negedge clk);
				check_result(s);
			end
			OP_IDLE: repeat (s.cycles) @(negedge clk);
			OP_INVAL: begin
				invalidate = 1'b1;
				@(negedge clk);
				invalidate = 1'b0;
				@(negedge clk);
			end
			OP_MODE: begin
				cpu_mode = cpu_mode + 4'd1;
				repeat (2) @(negedge clk);
			end
			default: begin	// disable for one cycle
				trace_enable = 1'b0;
				@(negedge clk);
				trace_enable = 1'b1;
				@(negedge clk);
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		trace_enable = 1'b1;
		trace_scale = 4'd0;	// base decay period
		cpu_mode = 4'd0;
		invalidate = 1'b0;
		pc = PARK_PC;
		pc_used = 1'b0;
		rename_stall = 1'b0;
		trace_in = '0;
		table_ready = 1'b0;
		lfsr_state = 16'd57504;
		build_groups();
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("result.hit after reset", result.hit, 1'b0);
		foreach (steps[i])
			apply_step(steps[i]);
		$display("STATUS: PASS");
		$finish;
	end

	// watchdog
	initial begin
		int longest;
		int limit;
		wait (table_ready);
		longest = 0;
		foreach (steps[i]) begin
			if (step_cycles(steps[i]) > longest)
				longest = step_cycles(steps[i]);
		end
		limit = steps.size() * longest + RESET_CYCLES + MARGIN_CYCLES;
		repeat (limit) @(posedge clk);
		$display("timeout: the step table did not complete within %0d cycles", limit);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- compile.f
tc_cfg_pkg.sv
tc_types_pkg.sv
tc_tag_array.sv
tc_data_array.sv
tc_line_alloc.sv
tc_fill_ctrl.sv
trace_cache_top.sv
tb_trace_cache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trace cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_trace_cache -o tb_trace_cache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_trace_cache > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
